/* src.f */
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
test/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module tb_rv_core \
    -o tb_rv_core > sim.log 2>&1 &&
./obj_dir/tb_rv_core >> sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

/* include/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// --------------------------------------------------
// Instruction encoders
// --------------------------------------------------
function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
endfunction

function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                input int rd);
    return {12'(imm), 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
endfunction

function automatic word_t enc_s(input int off, input int rs2, input int rs1,
                                input logic [2:0] f3);
    logic [11:0] o;
    o = 12'(off);
    return {o[11:5], 5'(rs2), 5'(rs1), f3, o[4:0], OPC_STORE};
endfunction

function automatic word_t enc_b(input int off, input int rs1, input int rs2,
                                input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], OPC_BRANCH};
endfunction

task automatic emit(input word_t w);
    prog[n_words] = w;
    n_words++;
endtask

// --------------------------------------------------
// Test program
// --------------------------------------------------
task automatic build_program();
    int imm;
    for (int i = 0; i < PROG_WORDS; i++) begin
        prog[i] = NOP_INSTR;
    end
    n_words = 0;
    emit(enc_i(256, 0, F3_ADD_SUB, 10));            // Store base
    emit(enc_i(-5, 0, F3_ADD_SUB, 1));
    emit(enc_i(3, 0, F3_ADD_SUB, 2));
    // R-type results stored back to back
    for (int f = 0; f < 8; f++) begin
        emit(enc_r(FUNCT7_BASE, 2, 1, 3'(f), 3));
        emit(enc_s(4 * f, 3, 10, F3_SW));
    end
    emit(enc_r(FUNCT7_ALT, 2, 1, F3_ADD_SUB, 3));
    emit(enc_s(32, 3, 10, F3_SW));
    emit(enc_r(FUNCT7_ALT, 2, 1, F3_SRL_SRA, 3));
    emit(enc_s(36, 3, 10, F3_SW));
    // I-type results stored one instruction apart
    for (int f = 0; f < 8; f++) begin
        imm = ((f >= 1 && f <= 3) || f == 5) ? 7 : -7;  // Signed and unsigned compares differ
        emit(enc_i(imm, 1, 3'(f), 4));
        emit(enc_i(1, 5, F3_ADD_SUB, 5));
        emit(enc_s(40 + 4 * f, 4, 10, F3_SW));
    end
    emit(enc_i('h407, 1, F3_SRL_SRA, 4));           // srai x4, x1, 7
    emit(enc_s(72, 4, 10, F3_SW));
    emit(enc_s(76, 5, 10, F3_SW));
    // x0 writes, base dependency, widths
    emit(enc_i(99, 1, F3_ADD_SUB, 0));
    emit(enc_s(80, 0, 10, F3_SW));
    emit(enc_i(64, 10, F3_ADD_SUB, 10));
    emit(enc_s(1, 1, 10, F3_SB));
    emit(enc_s(2, 1, 10, F3_SH));
    emit(enc_r(FUNCT7_BASE, 1, 1, F3_ADD_SUB, 6));
    emit(enc_r(FUNCT7_BASE, 6, 6, F3_ADD_SUB, 6));
    emit(enc_s(-4, 6, 10, F3_SW));
    // --------------------------------------------------
    // Branches
    // --------------------------------------------------
    emit(enc_b(12, 1, 1, F3_BEQ));                  // Taken, skips two stores
    emit(enc_s(100, 1, 10, F3_SW));
    emit(enc_s(104, 1, 10, F3_SW));
    emit(enc_b(8, 1, 2, F3_BEQ));                   // Not taken
    emit(enc_i(16, 0, F3_ADD_SUB, 14));
    emit(enc_b(8, 1, 2, F3_BNE));                   // Taken
    emit(enc_i(48, 14, F3_ADD_SUB, 14));
    emit(enc_s(0, 2, 14, F3_SW));                   // Address set by branch outcome
    emit(enc_b(8, 3, 3, F3_BNE));                   // Not taken
    emit(enc_i(4, 14, F3_ADD_SUB, 14));
    emit(enc_s(256, 14, 14, F3_SH));
    emit(enc_i(7, 0, F3_ADD_SUB, 15));
    emit(enc_b(16, 15, 0, F3_BNE));                 // Forwarded compare, skips three
    emit(enc_s(64, 15, 10, F3_SW));
    emit(enc_s(68, 15, 10, F3_SW));
    emit(enc_s(72, 15, 10, F3_SW));
    emit(enc_s(8, 15, 14, F3_SB));
    // Backward loop, three passes
    emit(enc_i(3, 0, F3_ADD_SUB, 16));
    emit(enc_i(-1, 16, F3_ADD_SUB, 16));
    emit(enc_i(4, 17, F3_ADD_SUB, 17));
    emit(enc_s(768, 16, 17, F3_SH));
    emit(enc_b(-12, 16, 0, F3_BNE));
    emit(enc_s(0, 17, 17, F3_SW));
endtask

// --------------------------------------------------
// Architectural reference
// --------------------------------------------------
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    word_t r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: r = (a < b) ? 32'd1 : 32'd0;
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

task automatic run_reference();
    word_t  x [32];
    word_t  ir;
    word_t  a;
    word_t  b;
    logic   alt;
    store_t st;
    int     pc;
    int     next_pc;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc = 0;
    while (pc < PROG_WORDS * 4) begin
        ir      = prog[pc / 4];
        a       = x[ir[19:15]];
        b       = x[ir[24:20]];
        next_pc = pc + 4;
        case (ir[6:0])
            OPC_OP, OPC_OP_IMM: begin
                if (ir[6:0] == OPC_OP_IMM) begin
                    b = {{20{ir[31]}}, ir[31:20]};
                end
                alt = ir[30] && (ir[6:0] == OPC_OP || ir[14:12] == F3_SRL_SRA);
                if (ir[11:7] != 5'd0) begin
                    x[ir[11:7]] = alu_ref(ir[14:12], alt, a, b);
                end
            end
            OPC_STORE: begin
                st.valid = 1'b1;
                st.addr  = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
                st.data  = b;
                st.width = mem_width_t'(ir[13:12]);
                expected.push_back(st);
            end
            OPC_BRANCH: begin
                if ((a == b) == (ir[14:12] == F3_BEQ)) begin
                    next_pc = pc + int'({{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0});
                end
            end
            default: ;
        endcase
        pc = next_pc;
    end
endtask

`endif

/* test/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int PROG_WORDS       = 96;
    localparam int WATCHDOG_CYCLES  = PROG_WORDS * 8 + 200;
    localparam int DRAIN_CYCLES     = 16;    // Catches stray stores after the last one
    localparam int FIRST_STORE_EDGE = 3;

    logic   clk         = 1'b0;
    logic   reset_n     = 1'b0;
    logic   instr_ready = 1'b0;
    word_t  instr;
    word_t  instr_addr;
    store_t store;

    word_t  prog [PROG_WORDS];
    int     n_words;
    store_t expected [$];
    integer seed              = 32'h7637_891a;
    int     reset_cycles      = 0;
    int     edges_since_reset = 0;
    logic   prev_ready        = 1'b0;
    logic   prev_redirect     = 1'b0;
    word_t  prev_addr         = '0;

    `include "tb_programs.svh"

    rv_core u_rv_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_ready (instr_ready),
        .instr       (instr),
        .instr_addr  (instr_addr),
        .store       (store)
    );

    always #2 clk = ~clk;

    // Instruction memory, NOP past the program
    function automatic word_t fetch_word(input word_t addr);
        if (addr >= PROG_WORDS * 4) begin
            return NOP_INSTR;
        end
        return prog[addr[9:2]];
    endfunction

    always_comb instr = fetch_word(instr_addr);

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        assert (act_v === exp_v) else begin
            stop_on_failure($sformatf("[ERROR] time=%0t %s expected=%h actual=%h",
                                      $time, name, exp_v, act_v));
        end
    endtask

    task automatic check_store();
        store_t exp_st;
        if (store.valid) begin
            if (edges_since_reset < FIRST_STORE_EDGE) begin
                stop_on_failure("Store strobe seen before any instruction could reach MEM");
            end else if (expected.size() == 0) begin
                stop_on_failure($sformatf("Unexpected store to address %h at time %0t",
                                          store.addr, $time));
            end else begin
                exp_st = expected.pop_front();
                check_word("store.addr", exp_st.addr, store.addr);
                check_word("store.data", exp_st.data, store.data);
                check_word("store.width", word_t'(exp_st.width), word_t'(store.width));
            end
        end
    endtask

    // Sample settled outputs, then drive the next inputs
    always @(negedge clk) begin
        if (!reset_n) begin
            check_word("instr_addr", '0, instr_addr);
            check_word("store.valid", '0, word_t'(store.valid));
            reset_cycles++;
            if (reset_cycles == 3) begin
                reset_n = 1'b1;
            end
        end else begin
            edges_since_reset++;
            check_store();
            if (!prev_ready && !prev_redirect) begin
                check_word("instr_addr", prev_addr, instr_addr);   // PC holds on stall
            end
        end
        if (reset_n) begin
            instr_ready = ($random(seed) & 3) != 0;              // High about 3 in 4
        end
        prev_ready    = instr_ready;
        prev_addr     = instr_addr;
        prev_redirect = u_rv_core.redirect.taken;
    end

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        build_program();
        run_reference();
        do begin
            @(posedge clk);
        end while (!reset_n || expected.size() != 0);
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_failure($sformatf("Watchdog expired after %0d cycles with %0d stores missing",
                                  WATCHDOG_CYCLES, expected.size()));
    end

endmodule

`default_nettype wire

/* design/rv_core.sv */
`default_nettype none

module rv_core (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                instr_ready,
    input  rv_isa_pkg::word_t   instr,
    output rv_isa_pkg::word_t   instr_addr,
    output rv_pipe_pkg::store_t store
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ifid_t     ifid;
    idex_t     idex;
    exmem_t    exmem;
    redirect_t redirect;
    wb_t       mem_fwd;
    wb_t       wb;

    rv_fetch u_rv_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_ready (instr_ready),
        .instr       (instr),
        .redirect    (redirect),
        .instr_addr  (instr_addr),
        .ifid        (ifid)
    );

    rv_decode u_rv_decode (
        .clk     (clk),
        .reset_n (reset_n),
        .ifid    (ifid),
        .flush   (redirect.taken),
        .wb      (wb),
        .idex    (idex)
    );

    rv_execute u_rv_execute (
        .clk      (clk),
        .reset_n  (reset_n),
        .idex     (idex),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb),
        .exmem    (exmem),
        .redirect (redirect)
    );

    // EX/MEM result seen by the forwarding path
    assign mem_fwd = '{reg_write: exmem.reg_write, rd: exmem.rd, data: exmem.result};

    // --------------------------------------------------
    // MEM stage, store port and MEM/WB register
    // --------------------------------------------------
    assign store = '{valid: exmem.mem_write, addr: exmem.result,
                     data: exmem.store_data, width: exmem.width};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb <= '0;
        end else begin
            wb.reg_write <= exmem.reg_write;
            wb.rd        <= exmem.rd;
            wb.data      <= exmem.result;   // No loads, ALU result only
        end
    end

endmodule

`default_nettype wire

/* design/rv_execute.sv */
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   reset_n,
    input  rv_pipe_pkg::idex_t     idex,
    input  rv_pipe_pkg::wb_t       mem_fwd,
    input  rv_pipe_pkg::wb_t       wb_fwd,
    output rv_pipe_pkg::exmem_t    exmem,
    output rv_pipe_pkg::redirect_t redirect
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t op_a;
    word_t op_b_reg;
    word_t alu_b;
    word_t alu_result;
    logic  take;

    // --------------------------------------------------
    // Forwarding
    // --------------------------------------------------
    // EX/MEM beats MEM/WB, x0 never forwards
    function automatic word_t fwd_select(
        input reg_idx_t rs,
        input word_t    regval,
        input wb_t      mem_src,
        input wb_t      wb_src
    );
        if (rs == '0) begin
            return regval;
        end
        if (mem_src.reg_write && mem_src.rd == rs) begin
            return mem_src.data;
        end
        if (wb_src.reg_write && wb_src.rd == rs) begin
            return wb_src.data;
        end
        return regval;
    endfunction

    assign op_a     = fwd_select(idex.rs1, idex.op1, mem_fwd, wb_fwd);
    assign op_b_reg = fwd_select(idex.rs2, idex.op2, mem_fwd, wb_fwd);
    assign alu_b    = idex.use_imm ? idex.imm : op_b_reg;

    rv_alu u_rv_alu (
        .op     (idex.alu_op),
        .a      (op_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // Branch test on this cycle's difference
    always_comb begin
        case (idex.branch_op)
            BEQ:     take = (alu_result == '0);
            BNE:     take = (alu_result != '0);
            default: take = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // EX/MEM register and redirect
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exmem    <= '0;
            redirect <= '0;
        end else if (redirect.taken) begin
            // Younger instruction in EX is squashed
            exmem    <= '0;
            redirect <= '0;
        end else begin
            exmem.result     <= alu_result;
            exmem.store_data <= op_b_reg;       // Full rs2, unshifted
            exmem.rd         <= idex.rd;
            exmem.reg_write  <= idex.reg_write;
            exmem.mem_write  <= idex.mem_write;
            exmem.width      <= idex.width;
            redirect.taken   <= take;
            redirect.target  <= idex.pc + idex.imm;
        end
    end

endmodule

`default_nettype wire

/* design/rv_decode.sv */
`default_nettype none

module rv_decode (
    input  logic               clk,
    input  logic               reset_n,
    input  rv_pipe_pkg::ifid_t ifid,
    input  logic               flush,
    input  rv_pipe_pkg::wb_t   wb,
    output rv_pipe_pkg::idex_t idex
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    instr_t ir;
    word_t  rdata1;
    word_t  rdata2;
    word_t  imm_i;
    word_t  imm_sh;
    word_t  imm_s;
    word_t  imm_b;
    logic   f7_base;
    logic   f7_alt;
    logic   legal;
    idex_t  dec;

    assign ir = ifid.instr;

    rv_regfile u_rv_regfile (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1     (ir.r_fmt.rs1),
        .rs2     (ir.r_fmt.rs2),
        .wb      (wb),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    // --------------------------------------------------
    // Immediates
    // --------------------------------------------------
    assign imm_i  = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
    assign imm_sh = {27'b0, ir.r_fmt.rs2};              // shamt sits in the rs2 field
    assign imm_s  = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
    assign imm_b  = {{19{ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                     ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};

    assign f7_base = (ir.r_fmt.funct7 == FUNCT7_BASE);
    assign f7_alt  = (ir.r_fmt.funct7 == FUNCT7_ALT);

    // --------------------------------------------------
    // Control decode
    // --------------------------------------------------
    always_comb begin
        dec       = '0;
        legal     = 1'b1;
        dec.pc    = ifid.pc;
        dec.rs1   = ir.r_fmt.rs1;
        dec.rs2   = ir.r_fmt.rs2;
        dec.rd    = ir.r_fmt.rd;
        dec.op1   = rdata1;
        dec.op2   = rdata2;
        dec.width = WORD;

        case (ir.r_fmt.opcode)
            OPC_OP: begin
                dec.reg_write = 1'b1;
                case (ir.r_fmt.funct3)
                    F3_ADD_SUB: dec.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec.alu_op = ALU_SLL;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_SRL_SRA: dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec.alu_op = ALU_OR;
                    default:    dec.alu_op = ALU_AND;
                endcase
                // Alt funct7 only on sub and sra
                legal = f7_base || (f7_alt && (ir.r_fmt.funct3 == F3_ADD_SUB ||
                                               ir.r_fmt.funct3 == F3_SRL_SRA));
            end

            OPC_OP_IMM: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_i;
                case (ir.i_fmt.funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_SLL: begin
                        dec.alu_op = ALU_SLL;
                        dec.imm    = imm_sh;
                        legal      = f7_base;
                    end
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_SRL_SRA: begin
                        dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                        dec.imm    = imm_sh;
                        legal      = f7_base || f7_alt;
                    end
                    F3_OR:      dec.alu_op = ALU_OR;
                    default:    dec.alu_op = ALU_AND;
                endcase
            end

            OPC_STORE: begin
                dec.mem_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_s;          // Address is rs1 + imm
                case (ir.s_fmt.funct3)
                    F3_SB:   dec.width = BYTE;
                    F3_SH:   dec.width = HALF;
                    F3_SW:   dec.width = WORD;
                    default: legal = 1'b0;
                endcase
            end

            OPC_BRANCH: begin
                dec.alu_op = ALU_SUB;           // Compare by subtraction
                dec.imm    = imm_b;
                case (ir.b_fmt.funct3)
                    F3_BEQ:  dec.branch_op = BEQ;
                    F3_BNE:  dec.branch_op = BNE;
                    default: legal = 1'b0;
                endcase
            end

            default: legal = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // ID/EX register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idex <= '0;
        end else if (flush || !legal) begin
            idex <= '0;                 // Bubble
        end else begin
            idex <= dec;
        end
    end

endmodule

`default_nettype wire

/* design/rv_fetch.sv */
`default_nettype none

module rv_fetch (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  instr_ready,
    input  rv_isa_pkg::word_t     instr,
    input  rv_pipe_pkg::redirect_t redirect,
    output rv_isa_pkg::word_t     instr_addr,
    output rv_pipe_pkg::ifid_t    ifid
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t pc;

    assign instr_addr = pc;

    // --------------------------------------------------
    // Program counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= '0;
        end else if (redirect.taken) begin
            pc <= redirect.target;          // Taken branch from EX/MEM
        end else if (instr_ready) begin
            pc <= pc + XLEN'(4);
        end
    end

    // --------------------------------------------------
    // IF/ID register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ifid.pc    <= '0;
            ifid.instr <= NOP_INSTR;
        end else if (redirect.taken || !instr_ready) begin
            ifid.pc    <= pc;
            ifid.instr <= NOP_INSTR;        // Bubble on stall or flush
        end else begin
            ifid.pc    <= pc;
            ifid.instr <= instr;
        end
    end

endmodule

`default_nettype wire

/* design/rv_regfile.sv */
`default_nettype none

module rv_regfile (
    input  logic                 clk,
    input  logic                 reset_n,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  rv_pipe_pkg::wb_t     wb,
    output rv_isa_pkg::word_t    rdata1,
    output rv_isa_pkg::word_t    rdata2
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t regs [1:31];     // x0 has no storage

    // Write-first read, so WB and ID can share a cycle
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rdata1 = read_port(rs1);
    assign rdata2 = read_port(rs2);

endmodule

`default_nettype wire

/* design/rv_alu.sv */
`default_nettype none

module rv_alu (
    input  rv_pipe_pkg::alu_op_t op,
    input  rv_isa_pkg::word_t    a,
    input  rv_isa_pkg::word_t    b,
    output rv_isa_pkg::word_t    result
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];      // Low five bits only

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Same code as funct3 of the store
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_width_t;

    typedef enum logic [1:0] {
        NONE,
        BEQ,
        BNE
    } branch_op_t;

    // --------------------------------------------------
    // Stage registers and ports
    // --------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::word_t  pc;
        rv_isa_pkg::instr_t instr;
    } ifid_t;

    typedef struct packed {
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    op1;
        rv_isa_pkg::word_t    op2;
        rv_isa_pkg::word_t    imm;
        alu_op_t              alu_op;
        logic                 use_imm;
        logic                 reg_write;
        logic                 mem_write;
        mem_width_t           width;
        branch_op_t           branch_op;
    } idex_t;

    typedef struct packed {
        rv_isa_pkg::word_t    result;
        rv_isa_pkg::word_t    store_data;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
        logic                 mem_write;
        mem_width_t           width;
    } exmem_t;

    typedef struct packed {
        logic                 reg_write;    // Doubles as valid
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    data;
    } wb_t;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t addr;
        rv_isa_pkg::word_t data;
        mem_width_t        width;
    } store_t;

    typedef struct packed {
        logic              taken;
        rv_isa_pkg::word_t target;
    } redirect_t;

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Store and branch funct3
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // sub, sra, srai

    localparam word_t NOP_INSTR = 32'h0000_0013;      // addi x0, x0, 0

    // --------------------------------------------------
    // Instruction formats
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_t;

endpackage

`default_nettype wire
